/* Makefile */
# Verilator build and run for zports_lite

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = zports_tb
FILELIST  = zports_lite.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/zports_props.sv */
/* zports_lite bus properties
   chip select, read enable and sd strobe rules on the top level */

`timescale 1ns/100ps
`default_nettype none

module zports_props (
	input wire                        zclk,
	input wire                        rst_n,
	input wire zports_pkg::zbus_t     bus,
	input wire                        dataout,
	input wire                        porthit,
	input wire zports_pkg::ide_pins_t ide,
	input wire zports_pkg::periph_t   periph
);

	// one ide device selected at a time
	cs_exclusive: assert property (@(posedge zclk) disable iff (!rst_n)
		!(!ide.ide_cs0_n && !ide.ide_cs1_n))
	else
		$error("ide_cs0_n and ide_cs1_n low together");

	drive_needs_hit: assert property (@(posedge zclk) disable iff (!rst_n)
		dataout |-> porthit)   // no data driven on an unclaimed port
	else
		$error("dataout high without porthit");

	sd_start_single: assert property (@(posedge zclk) disable iff (!rst_n)
		periph.sd_start |=> !periph.sd_start)
	else
		$error("sd_start held longer than one cycle");

	// device read strobe only inside a cpu read
	ide_rd_idle: assert property (@(posedge zclk) disable iff (!rst_n)
		bus.rd_n |-> ide.ide_rd_n)
	else
		$error("ide_rd_n low while rd_n high");

endmodule

bind zports_lite zports_props u_props (
	.zclk    (zclk),
	.rst_n   (rst_n),
	.bus     (bus),
	.dataout (dataout),
	.porthit (porthit),
	.ide     (ide),
	.periph  (periph)
);

`default_nettype wire

/* testbench/zports_tb.sv */
/* zports_lite testbench
   directed z80 io cycles over keyboard, paging, ide, sd and ay ports */

`timescale 1ns/100ps
`default_nettype none

`include "zports_macros.svh"

module zports_tb;

	localparam int TIMEOUT_CYCLES = 400;   // ~25 bus cycles of 4 clocks, plus margin

	logic                  zclk;
	logic                  rst_n;
	zports_pkg::zbus_t     bus;
	logic [15:0]           idein;
	logic [4:0]            keys_in;
	logic                  tape_read;
	logic [7:0]            sd_dataout;
	logic [7:0]            dout;
	logic                  dataout;
	logic                  porthit;
	zports_pkg::ide_pins_t ide;
	zports_pkg::pager_t    pager;
	zports_pkg::periph_t   periph;

	// outputs seen in the middle of the last bus cycle
	logic [7:0]            mid_dout;
	logic                  mid_dataout;
	logic                  mid_porthit;
	zports_pkg::ide_pins_t mid_ide;
	zports_pkg::periph_t   mid_periph;
	int                    cycle_count = 0;
	int                    sd_pulses = 0;   // sd_start pulses so far
	int unsigned           seed_val;

	zports_lite u_dut (
		.zclk       (zclk),
		.rst_n      (rst_n),
		.bus        (bus),
		.idein      (idein),
		.keys_in    (keys_in),
		.tape_read  (tape_read),
		.sd_dataout (sd_dataout),
		.dout       (dout),
		.dataout    (dataout),
		.porthit    (porthit),
		.ide        (ide),
		.pager      (pager),
		.periph     (periph)
	);

	initial
	begin
		zclk = 1'b0;
		forever
			#2 zclk = ~zclk;   // 4 ns period
	end

	always @(posedge zclk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: tests still running after %0d cycles", cycle_count);
			abort_run();
		end
	end

	// pulses counted away from the edge
	always @(negedge zclk)
	begin
		if (periph.sd_start)
			sd_pulses = sd_pulses + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers

	task automatic abort_run();
	begin
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	end
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
	begin
		assert (actual === expected)
		else
		begin
			$display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			abort_run();
		end
	end
	endtask

	task automatic capture_outputs();
	begin
		mid_dout    = dout;
		mid_dataout = dataout;
		mid_porthit = porthit;
		mid_ide     = ide;
		mid_periph  = periph;
	end
	endtask

	// one 3-clock io cycle, entered 1 ns after a rising edge
	task automatic io_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic is_read);
	begin
		bus.a      = addr;
		bus.din    = data;
		bus.iorq_n = 1'b0;
		bus.rd_n   = ~is_read;
		bus.wr_n   = is_read;
		repeat (2) @(posedge zclk);
		#1;   // strobe edge passed, register writes visible
		capture_outputs();
		@(posedge zclk);
		#1;
		bus.iorq_n = 1'b1;
		bus.rd_n   = 1'b1;
		bus.wr_n   = 1'b1;
		@(posedge zclk);   // idle cycle
		#1;
	end
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
	begin
		io_cycle(addr, data, 1'b0);
	end
	endtask

	task automatic io_read(input logic [15:0] addr);
	begin
		io_cycle(addr, 8'h00, 1'b1);
	end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic reset_and_unclaimed();
	begin
		check_value("sdcs_n", 16'(periph.sdcs_n), 16'h1);
		check_value("p7ffd", 16'(pager.p7ffd), 16'h0);
		check_value("peff7", 16'(pager.peff7), 16'h0);
		check_value("sd_start", 16'(periph.sd_start), 16'h0);
		check_value("ide_rd_n", 16'(ide.ide_rd_n), 16'h1);
		check_value("ide_wr_n", 16'(ide.ide_wr_n), 16'h1);
		io_read(16'h1200);   // low byte 00, nobody decodes it
		check_value("porthit", 16'(mid_porthit), 16'h0);
		check_value("dataout", 16'(mid_dataout), 16'h0);
		check_value("dout", 16'(mid_dout), 16'h00FF);
	end
	endtask

	task automatic border_and_keyboard();
		logic [15:0] addr;
		logic [7:0]  d;
		logic [7:0]  want;
	begin
		addr = {8'($urandom), `ZP_PORT_FE};
		d    = 8'($urandom);
		io_write(addr, d);
		check_value("border", 16'(periph.border), 16'({~addr[3], d[2:0]}));
		addr = {8'($urandom), `ZP_PORT_F6};   // alias, a3 low
		d    = 8'($urandom);
		io_write(addr, d);
		check_value("border", 16'(periph.border), 16'({~addr[3], d[2:0]}));
		keys_in   = 5'($urandom);
		tape_read = 1'($urandom);
		want      = {1'b1, tape_read, 1'b0, keys_in};
		io_read({8'($urandom), `ZP_PORT_FE});
		check_value("dout", 16'(mid_dout), 16'(want));
		check_value("dataout", 16'(mid_dataout), 16'h1);
	end
	endtask

	task automatic paging_and_lock();
		logic [7:0] v7;
		logic [7:0] ve;
	begin
		v7 = 8'($urandom) | 8'h20;   // lock48 bit, armed later by eff7
		io_write({8'h7F, `ZP_PORT_FD}, v7);
		check_value("p7ffd", 16'(pager.p7ffd), 16'(v7));
		check_value("pent1m_page", 16'(pager.pent1m_page), 16'({v7[7:5], v7[2:0]}));
		check_value("pent1m_rom", 16'(pager.pent1m_rom), 16'(v7[4]));
		ve = 8'($urandom) | 8'h04;   // 1m off
		io_write({8'hEF, `ZP_PORT_F7}, ve);
		check_value("p7ffd", 16'(pager.p7ffd), 16'({3'b000, v7[4:0]}));
		check_value("peff7", 16'(pager.peff7),
			16'({ve[7], 1'b0, ve[5:4], 3'b000, ve[0]}));
		check_value("pent1m_1m_on", 16'(pager.pent1m_1m_on), 16'h0);
		check_value("pent1m_ram0_0", 16'(pager.pent1m_ram0_0), 16'(ve[3]));
		io_write({8'h7F, `ZP_PORT_FD}, ~v7);   // locked, must be ignored
		check_value("p7ffd", 16'(pager.p7ffd), 16'({3'b000, v7[4:0]}));
		check_value("pent1m_page", 16'(pager.pent1m_page), 16'({v7[7:5], v7[2:0]}));
	end
	endtask

	task automatic ide_transfers();
		logic [7:0]  hi;
		logic [7:0]  lo;
		logic [15:0] word;
	begin
		hi = 8'($urandom);
		lo = 8'($urandom);
		io_write({8'h00, `ZP_NIDE11}, hi);
		check_value("ide_wr_n", 16'(mid_ide.ide_wr_n), 16'h1);   // high byte held only
		io_write({8'h00, `ZP_NIDE10}, lo);
		check_value("ide_wr_n", 16'(mid_ide.ide_wr_n), 16'h0);
		check_value("ide_cs0_n", 16'(mid_ide.ide_cs0_n), 16'h0);
		check_value("ide_cs1_n", 16'(mid_ide.ide_cs1_n), 16'h1);
		check_value("ide_a", 16'(mid_ide.ide_a), 16'h0);   // data register
		check_value("idedataout", 16'(mid_ide.idedataout), 16'h1);
		check_value("ideout", mid_ide.ideout, {hi, lo});

		// normal mode, 10 then 11
		word  = 16'($urandom);
		idein = word;
		io_read({8'h00, `ZP_NIDE10});
		check_value("dout", 16'(mid_dout), 16'(word[7:0]));
		check_value("ide_rd_n", 16'(mid_ide.ide_rd_n), 16'h0);
		check_value("idedataout", 16'(mid_ide.idedataout), 16'h0);   // device drives
		idein = ~word;   // high byte must come from the latch
		io_read({8'h00, `ZP_NIDE11});
		check_value("dout", 16'(mid_dout), 16'(word[15:8]));

		// nemo-divide, 10 twice
		word  = 16'($urandom);
		idein = word;
		io_read({8'h00, `ZP_NIDE10});
		check_value("dout", 16'(mid_dout), 16'(word[7:0]));
		idein = ~word;
		io_read({8'h00, `ZP_NIDE10});
		check_value("dout", 16'(mid_dout), 16'(word[15:8]));

		// c8 selects the control block, register 6
		word  = 16'($urandom);
		idein = word;
		io_read({8'h00, `ZP_NIDEC8});
		check_value("ide_cs1_n", 16'(mid_ide.ide_cs1_n), 16'h0);
		check_value("ide_cs0_n", 16'(mid_ide.ide_cs0_n), 16'h1);
		check_value("ide_a", 16'(mid_ide.ide_a), 16'h6);
		check_value("dout", 16'(mid_dout), 16'(word[7:0]));
	end
	endtask

	task automatic sd_card_ports();
		logic [7:0] d;
		int         base;
	begin
		d = 8'($urandom);
		io_write({8'h00, `ZP_SDCFG}, d);
		check_value("sdcs_n", 16'(periph.sdcs_n), 16'(d[1]));
		io_write({8'h00, `ZP_SDCFG}, ~d);   // other polarity
		check_value("sdcs_n", 16'(periph.sdcs_n), 16'(!d[1]));
		base = sd_pulses;
		d    = 8'($urandom);
		io_write({8'h00, `ZP_SDDAT}, d);
		check_value("sd_start pulses", 16'(sd_pulses - base), 16'h1);
		check_value("sd_datain", 16'(mid_periph.sd_datain), 16'(d));
		check_value("sd_datain", 16'(periph.sd_datain), 16'h00FF);   // idle bus
		sd_dataout = 8'($urandom);
		io_read({8'h00, `ZP_SDDAT});
		check_value("dout", 16'(mid_dout), 16'(sd_dataout));
		check_value("dataout", 16'(mid_dataout), 16'h1);
		check_value("sd_start pulses", 16'(sd_pulses - base), 16'h2);
	end
	endtask

	task automatic ay_control();
	begin
		io_write(16'hFFFD, 8'($urandom));   // register select
		check_value("ay_bc1", 16'(mid_periph.ay_bc1), 16'h1);
		check_value("ay_bdir", 16'(mid_periph.ay_bdir), 16'h1);
		io_write(16'hBFFD, 8'($urandom));   // data write
		check_value("ay_bc1", 16'(mid_periph.ay_bc1), 16'h0);
		check_value("ay_bdir", 16'(mid_periph.ay_bdir), 16'h1);
		io_read(16'hFFFD);   // answered by the ay itself
		check_value("porthit", 16'(mid_porthit), 16'h1);
		check_value("dataout", 16'(mid_dataout), 16'h0);
	end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence

	initial
	begin
		seed_val   = $urandom(32'hb8a067b0);
		rst_n      = 1'b0;
		bus        = '{a: 16'h0000, din: 8'h00, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
		idein      = 16'h0000;
		keys_in    = 5'h1F;   // no key pressed
		tape_read  = 1'b0;
		sd_dataout = 8'hFF;
		repeat (2) @(posedge zclk);
		#1;
		rst_n = 1'b1;
		@(posedge zclk);
		#1;
		reset_and_unclaimed();
		border_and_keyboard();
		paging_and_lock();
		ide_transfers();
		sd_card_ports();
		ay_control();
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/ide_bridge.sv */
/* nemo ide bridge
   8 to 16 bit data path with normal and nemo-divide access sequences */

`timescale 1ns/100ps
`default_nettype none

`include "zports_macros.svh"

module ide_bridge (
	input  wire                      zclk,
	input  wire                      rst_n,
	input  wire zports_pkg::zbus_t   bus,
	input  wire zports_pkg::io_strobe_t strobe,
	input  wire [`ZP_IDE_W-1:0]      idein,
	output zports_pkg::ide_pins_t    ide,
	output zports_pkg::rd_resp_t     resp
);

	wire  [7:0]           loa = bus.a[7:0];
	logic                 ide_ports;     // physical ide port, all but 11
	wire                  ide_acc;       // 11 or any physical port
	wire                  ide_strb;      // first cycle of an ide access
	logic                 ide_rd_trig;   // nemo-divide read trigger
	logic                 ide_wrlo_trig;
	logic                 ide_wrhi_trig;
	logic                 ide_rd_latch;  // trigger state held over the read cycle
	logic                 ide_wrlo_latch;
	logic                 ide_wrhi_latch;
	logic [`ZP_IDE_W-1:0] idewrreg;      // byte written ahead of its partner
	logic [7:0]           idehiin;       // high byte kept from the low read
	wire                  rd10_hi;       // second read of 10 returns the high byte

	always_comb
	begin
		case (loa)
			`ZP_NIDE_EVEN_LIST: ide_ports = 1'b1;
			default:            ide_ports = 1'b0;
		endcase
	end

	assign ide_acc  = ide_ports | (loa == `ZP_NIDE11);
	assign ide_strb = ide_acc & (strobe.port_rd | strobe.port_wr);

	////////////////////////////////////////////////////////////////////////////
	// access triggers

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ide_rd_trig   <= 1'b0;
			ide_wrlo_trig <= 1'b0;
			ide_wrhi_trig <= 1'b0;
		end
		else
		begin
			if ((loa == `ZP_NIDE10) && strobe.port_rd && !ide_rd_trig)
				ide_rd_trig <= 1'b1;          // low half read
			else if (ide_strb)
				ide_rd_trig <= 1'b0;

			if (ide_strb)
			begin
				ide_wrhi_trig <= (loa == `ZP_NIDE11) & strobe.port_wr;
				ide_wrlo_trig <= (loa == `ZP_NIDE10) & strobe.port_wr &
				                 ~ide_wrhi_trig & ~ide_wrlo_trig;   // first write of 10
			end
		end
	end

	// trigger copies, frozen while rd_n or wr_n is low
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ide_rd_latch   <= 1'b0;
			ide_wrlo_latch <= 1'b0;
			ide_wrhi_latch <= 1'b0;
		end
		else
		begin
			if (bus.rd_n)
				ide_rd_latch <= ide_rd_trig;
			if (bus.wr_n)
			begin
				ide_wrlo_latch <= ide_wrlo_trig;
				ide_wrhi_latch <= ide_wrhi_trig;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// data registers

	always_ff @(posedge zclk)
	begin
		if (strobe.port_wr && (loa == `ZP_NIDE11))
			idewrreg[`ZP_IDE_W-1:8] <= bus.din;
		if (strobe.port_wr && (loa == `ZP_NIDE10) && !ide_wrlo_trig)
			idewrreg[7:0] <= bus.din;
		if (strobe.port_rd && (loa == `ZP_NIDE10) && !ide_rd_trig)
			idehiin <= idein[`ZP_IDE_W-1:8];   // keep high half for later
	end

	assign rd10_hi = ide_rd_latch & (loa == `ZP_NIDE10);

	always_comb
	begin
		ide.ide_a      = loa[7:5];
		ide.ide_cs0_n  = ~ide_ports | (loa == `ZP_NIDEC8);
		ide.ide_cs1_n  = ~ide_ports | (loa != `ZP_NIDEC8);
		ide.ide_rd_n   = bus.iorq_n | bus.rd_n | ~ide_ports | rd10_hi;   // no strobe on hi read
		// first write of 10 only fills the register
		ide.ide_wr_n   = bus.iorq_n | bus.wr_n | ~ide_ports |
		                 ((loa == `ZP_NIDE10) & ~ide_wrlo_latch & ~ide_wrhi_latch);
		ide.idedataout = ide.ide_rd_n;
		ide.ideout[`ZP_IDE_W-1:8] = ide_wrhi_latch ? idewrreg[`ZP_IDE_W-1:8] : bus.din;
		ide.ideout[7:0]           = ide_wrlo_latch ? idewrreg[7:0] : bus.din;
	end

	assign resp.hit   = ide_acc;
	assign resp.drive = ide_acc;
	assign resp.data  = ((loa == `ZP_NIDE11) || rd10_hi) ? idehiin : idein[7:0];

endmodule

`default_nettype wire

/* verilog/mem_pager.sv */
/* pentagon-1m memory pager
   7ffd and eff7 paging registers with the 48k lock */

`timescale 1ns/100ps
`default_nettype none

`include "zports_macros.svh"

module mem_pager (
	input  wire                         zclk,
	input  wire                         rst_n,
	input  wire zports_pkg::zbus_t      bus,
	input  wire zports_pkg::io_strobe_t strobe,
	output zports_pkg::pager_t          pager,
	output zports_pkg::rd_resp_t        resp
);

	wire  [7:0] loa = bus.a[7:0];
	logic [7:0] p7ffd_int;   // 2..0 page, 3 screen, 4 rom, 5 lock48, 7..6 high page
	logic [7:0] peff7_int;   // 2 disables 1m, 3 ram0 at 0000
	wire        block1m;
	wire        block7ffd;
	wire        wr_7ffd;
	wire        wr_eff7;

	assign block1m   = peff7_int[2];
	assign block7ffd = p7ffd_int[5] & block1m;   // 48k lock

	assign wr_7ffd = strobe.port_wr & (loa == `ZP_PORT_FD) & ~bus.a[15];
	assign wr_eff7 = strobe.port_wr & (loa == `ZP_PORT_F7) & bus.a[8] & ~bus.a[12];

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_int <= 8'h00;
			peff7_int <= 8'h00;
		end
		else
		begin
			if (wr_7ffd && !block7ffd)
				p7ffd_int <= bus.din;
			if (wr_eff7)
				peff7_int <= bus.din;
		end
	end

	always_comb
	begin
		pager.p7ffd = {(block1m ? 3'b000 : p7ffd_int[7:5]), p7ffd_int[4:0]};
		if (block1m)
			pager.peff7 = {peff7_int[7], 1'b0, peff7_int[5:4], 3'b000, peff7_int[0]};
		else
			pager.peff7 = peff7_int;
		pager.pent1m_page   = {p7ffd_int[7:5], p7ffd_int[2:0]};
		pager.pent1m_rom    = p7ffd_int[4];
		pager.pent1m_1m_on  = ~peff7_int[2];
		pager.pent1m_ram0_0 = peff7_int[3];
	end

	// f7 reads float high
	assign resp.hit   = (loa == `ZP_PORT_F7);
	assign resp.drive = resp.hit;
	assign resp.data  = 8'hFF;

endmodule

`default_nettype wire

/* verilog/periph_ports.sv */
/* peripheral ports
   keyboard and border, ay bus control, sd card select and data start */

`timescale 1ns/100ps
`default_nettype none

`include "zports_macros.svh"

module periph_ports (
	input  wire                         zclk,
	input  wire                         rst_n,
	input  wire zports_pkg::zbus_t      bus,
	input  wire zports_pkg::io_strobe_t strobe,
	input  wire [4:0]                   keys_in,
	input  wire                         tape_read,
	input  wire [`ZP_DATA_W-1:0]        sd_dataout,
	output zports_pkg::periph_t         periph,
	output zports_pkg::rd_resp_t        resp
);

	wire  [7:0] loa = bus.a[7:0];
	wire        fe_sel;        // fe or its f6 alias
	wire        ay_sel;        // fffd, the ay answers it
	logic       pre_bc1;
	logic       pre_bdir;

	assign fe_sel = (loa == `ZP_PORT_FE) | (loa == `ZP_PORT_F6);
	assign ay_sel = (loa == `ZP_PORT_FD) & (bus.a[15:14] == 2'b11);

	////////////////////////////////////////////////////////////////////////////
	// border and sd chip select

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			periph.border <= 4'h0;
			periph.sdcs_n <= 1'b1;   // card deselected
		end
		else
		begin
			if (strobe.port_wr && fe_sel)
				periph.border <= {~bus.a[3], bus.din[2:0]};
			if (strobe.port_wr && (loa == `ZP_SDCFG))
				periph.sdcs_n <= bus.din[1];
		end
	end

	// ay decode on a15..14
	always_comb
	begin
		pre_bc1  = 1'b0;
		pre_bdir = 1'b0;
		if (loa == `ZP_PORT_FD)
		begin
			pre_bc1  = (bus.a[15:14] == 2'b11);
			pre_bdir = bus.a[15];
		end
	end

	assign periph.ay_bc1    = pre_bc1 & ~bus.iorq_n & (~bus.rd_n | ~bus.wr_n);
	assign periph.ay_bdir   = pre_bdir & ~bus.iorq_n & ~bus.wr_n;
	assign periph.sd_start  = (strobe.port_wr | strobe.port_rd) & (loa == `ZP_SDDAT);
	assign periph.sd_datain = bus.wr_n ? 8'hFF : bus.din;

	////////////////////////////////////////////////////////////////////////////
	// read side

	assign resp.hit   = fe_sel | (loa == `ZP_PORT_FD) | (loa == `ZP_SDCFG) | (loa == `ZP_SDDAT);
	assign resp.drive = resp.hit & ~ay_sel;

	always_comb
	begin
		if (fe_sel)
			resp.data = {1'b1, tape_read, 1'b0, keys_in};
		else if (loa == `ZP_SDCFG)
			resp.data = 8'h00;   // card present, writable
		else if (loa == `ZP_SDDAT)
			resp.data = sd_dataout;
		else
			resp.data = 8'hFF;
	end

endmodule

`default_nettype wire

/* verilog/zbus_strobe.sv */
/* z80 io cycle strobes
   one zclk pulse at the start of each io read or write */

`timescale 1ns/100ps
`default_nettype none

module zbus_strobe (
	input  wire                    zclk,
	input  wire                    rst_n,
	input  wire zports_pkg::zbus_t bus,
	output zports_pkg::io_strobe_t strobe
);

	logic iowr_reg;   // io write seen on previous edge
	logic iord_reg;   // io read seen on previous edge
	wire  iowr_now;
	wire  iord_now;

	assign iowr_now = ~(bus.iorq_n | bus.wr_n);
	assign iord_now = ~(bus.iorq_n | bus.rd_n);

	////////////////////////////////////////////////////////////////////////////
	// edge detect on the io conditions

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_reg <= 1'b0;
			iord_reg <= 1'b0;
		end
		else
		begin
			iowr_reg <= iowr_now;
			iord_reg <= iord_now;
		end
	end

	// strobe only on the first edge of the access
	// so a stretched cycle never writes twice
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			strobe.port_wr <= 1'b0;
			strobe.port_rd <= 1'b0;
		end
		else
		begin
			strobe.port_wr <= iowr_now & ~iowr_reg;
			strobe.port_rd <= iord_now & ~iord_reg;
		end
	end

endmodule

`default_nettype wire

/* verilog/zports_lite.sv */
/* zports_lite top
   joins strobe, ide, pager and peripheral blocks onto one read bus */

`timescale 1ns/100ps
`default_nettype none

`include "zports_macros.svh"

module zports_lite (
	input  wire                    zclk,
	input  wire                    rst_n,
	input  wire zports_pkg::zbus_t bus,
	input  wire [`ZP_IDE_W-1:0]    idein,
	input  wire [4:0]              keys_in,
	input  wire                    tape_read,
	input  wire [`ZP_DATA_W-1:0]   sd_dataout,
	output logic [`ZP_DATA_W-1:0]  dout,
	output logic                   dataout,
	output logic                   porthit,
	output zports_pkg::ide_pins_t  ide,
	output zports_pkg::pager_t     pager,
	output zports_pkg::periph_t    periph
);

	zports_pkg::io_strobe_t strobe;
	zports_pkg::rd_resp_t   resp_ide;
	zports_pkg::rd_resp_t   resp_pg;
	zports_pkg::rd_resp_t   resp_per;
	wire                    any_drive;

	zbus_strobe u_strobe (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.bus    (bus),
		.strobe (strobe)
	);

	ide_bridge u_ide (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.bus    (bus),
		.strobe (strobe),
		.idein  (idein),
		.ide    (ide),
		.resp   (resp_ide)
	);

	mem_pager u_pager (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.bus    (bus),
		.strobe (strobe),
		.pager  (pager),
		.resp   (resp_pg)
	);

	periph_ports u_periph (
		.zclk       (zclk),
		.rst_n      (rst_n),
		.bus        (bus),
		.strobe     (strobe),
		.keys_in    (keys_in),
		.tape_read  (tape_read),
		.sd_dataout (sd_dataout),
		.periph     (periph),
		.resp       (resp_per)
	);

	////////////////////////////////////////////////////////////////////////////
	// read response mux

	assign any_drive = resp_ide.drive | resp_pg.drive | resp_per.drive;

	always_comb
	begin
		porthit = resp_ide.hit | resp_pg.hit | resp_per.hit;
		// port decodes are disjoint, order does not matter
		if (resp_ide.drive)
			dout = resp_ide.data;
		else if (resp_pg.drive)
			dout = resp_pg.data;
		else if (resp_per.drive)
			dout = resp_per.data;
		else
			dout = 8'hFF;   // idle bus
		dataout = porthit & ~bus.iorq_n & ~bus.rd_n & any_drive;
	end

endmodule

`default_nettype wire

/* verilog/zports_macros.svh */
/* zports port map
   low-byte i/o addresses and bus widths shared by the port blocks */

`ifndef ZPORTS_MACROS_SVH
`define ZPORTS_MACROS_SVH

// bus widths
`define ZP_ADDR_W 16
`define ZP_DATA_W 8
`define ZP_IDE_W  16

// keyboard, border and ay ports
`define ZP_PORT_FE 8'hFE
`define ZP_PORT_F6 8'hF6
`define ZP_PORT_FD 8'hFD
`define ZP_PORT_F7 8'hF7

// nemo ide ports
`define ZP_NIDE10 8'h10
`define ZP_NIDE11 8'h11
`define ZP_NIDEC8 8'hC8
`define ZP_NIDE_EVEN_LIST `ZP_NIDE10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0, `ZP_NIDEC8

// z-controller sd card
`define ZP_SDCFG 8'h77
`define ZP_SDDAT 8'h57

`endif

/* verilog/zports_pkg.sv */
/* zports types
   packed bundles for the cpu bus, strobes, read answers and block outputs */

`default_nettype none

`include "zports_macros.svh"

package zports_pkg;

	// cpu side of the z80 bus
	typedef struct packed {
		logic [`ZP_ADDR_W-1:0] a;
		logic [`ZP_DATA_W-1:0] din;
		logic                  iorq_n;
		logic                  rd_n;
		logic                  wr_n;
	} zbus_t;

	typedef struct packed {
		logic port_wr;   // first cycle of an io write
		logic port_rd;   // first cycle of an io read
	} io_strobe_t;

	// one block's answer on the shared read bus
	typedef struct packed {
		logic                  hit;    // port claimed
		logic                  drive;  // data comes from here, not an external chip
		logic [`ZP_DATA_W-1:0] data;
	} rd_resp_t;

	typedef struct packed {
		logic [`ZP_IDE_W-1:0] ideout;
		logic [2:0]           ide_a;
		logic                 ide_cs0_n;
		logic                 ide_cs1_n;
		logic                 ide_rd_n;
		logic                 ide_wr_n;
		logic                 idedataout;   // low when the device drives the data lines
	} ide_pins_t;

	typedef struct packed {
		logic [7:0] p7ffd;
		logic [7:0] peff7;
		logic [5:0] pent1m_page;
		logic       pent1m_rom;
		logic       pent1m_1m_on;
		logic       pent1m_ram0_0;
	} pager_t;

	typedef struct packed {
		logic [3:0]            border;
		logic                  ay_bc1;
		logic                  ay_bdir;
		logic                  sdcs_n;
		logic                  sd_start;
		logic [`ZP_DATA_W-1:0] sd_datain;
	} periph_t;

endpackage

`default_nettype wire

/* zports_lite.f */
+incdir+verilog
verilog/zports_pkg.sv
verilog/zbus_strobe.sv
verilog/ide_bridge.sv
verilog/mem_pager.sv
verilog/periph_ports.sv
verilog/zports_lite.sv
testbench/zports_props.sv
testbench/zports_tb.sv
